// File: rtl/error_accum.sv
/* steering error accumulator
   folds weighted readings into a signed sum and saturates it
   at the end of each frame */
`timescale 1ns/10ps
`default_nettype none

module error_accum (
    input  wire                          clk,
    input  wire                          rst_n,
    input  line_follow_pkg::sample_t     sample,
    input  wire                          sample_vld,
    output logic signed [11:0]           error,
    output logic                         error_vld,
    output logic [7:0]                   LEDs
);

    logic signed [15:0] accum;
    logic signed [15:0] term;
    logic signed [15:0] base;
    logic signed [15:0] sum;
    logic               first;

    // first channel of the inner pair opens a frame
    assign first = (sample.pair == line_follow_pkg::pair_inner) && !sample.negate;

    always_comb begin
        term = $signed({4'b0000, sample.value} << sample.pair);   // x1, x2, x4
        base = first ? 16'sd0 : accum;
        if (sample.negate)
            sum = base - term;
        else
            sum = base + term;
    end

    always_ff @(posedge clk) begin
        if (sample_vld)
            accum <= sum;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error     <= '0;
            error_vld <= 1'b0;
        end else begin
            error_vld <= sample_vld && sample.last;
            if (sample_vld && sample.last)
                error <= line_follow_pkg::sat12(sum);
        end
    end

    assign LEDs = error[11:4];

endmodule

`default_nettype wire

// File: rtl/ir_emitter_pwm.sv
/* IR emitter PWM
   8 bit duty generator, routed to the selected pair only */
`timescale 1ns/10ps
`default_nettype none

module ir_emitter_pwm (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         emit_en,
    input  line_follow_pkg::ir_pair_t   emit_pair,
    output logic                        ir_in_en,
    output logic                        ir_mid_en,
    output logic                        ir_out_en
);

    logic [7:0] cnt;
    logic       pwm;

    // held at zero while dark, so every enable starts a fresh period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cnt <= '0;
        else if (emit_en)
            cnt <= cnt + 1'b1;   // wraps every 256
        else
            cnt <= '0;
    end

    assign pwm = emit_en && (cnt < line_follow_pkg::pwm_duty);

    assign ir_in_en  = pwm && (emit_pair == line_follow_pkg::pair_inner);
    assign ir_mid_en = pwm && (emit_pair == line_follow_pkg::pair_mid);
    assign ir_out_en = pwm && (emit_pair == line_follow_pkg::pair_outer);

endmodule

`default_nettype wire

// File: rtl/line_follow_pkg.sv
/* line follower shared definitions
   A2D width, channel order, sample and motor structs, gains */
`default_nettype none

package line_follow_pkg;

    localparam int a2d_w = 12;

    typedef logic [2:0] chan_t;

    // pair code doubles as the weight shift (x1, x2, x4)
    typedef enum logic [1:0] {
        pair_inner = 2'd0,
        pair_mid   = 2'd1,
        pair_outer = 2'd2
    } ir_pair_t;

    typedef struct packed {
        logic [a2d_w-1:0] value;
        ir_pair_t         pair;
        logic             negate;   // second channel of a pair
        logic             last;     // channel 7, closes the frame
    } sample_t;

    typedef struct packed {
        logic [10:0] lft;
        logic [10:0] rht;
    } motor_cmd_t;

    localparam logic [7:0]  pwm_duty = 8'd140;
    localparam logic [13:0] p_term   = 14'd13952;
    localparam logic [11:0] i_term   = 12'd1280;
    localparam logic [10:0] fwd_max  = 11'd1792;

    // scan order 1, 0, 4, 2, 3, 7
    function automatic chan_t chan_at(input logic [2:0] idx);
        case (idx)
            3'd0:    return 3'd1;
            3'd1:    return 3'd0;
            3'd2:    return 3'd4;
            3'd3:    return 3'd2;
            3'd4:    return 3'd3;
            default: return 3'd7;
        endcase
    endfunction

    // clamp to the signed 12 bit range
    function automatic logic signed [11:0] sat12(input logic signed [15:0] v);
        if (v > 16'sd2047)
            return 12'h7ff;
        else if (v < -16'sd2048)
            return 12'h800;
        return v[11:0];
    endfunction

endpackage

`default_nettype wire

// File: rtl/motion_cntrl.sv
/* line following motion controller
   sequencer, emitter PWM, error accumulator and PI stage in a chain */
`timescale 1ns/10ps
`default_nettype none

module motion_cntrl #(
    parameter int settle_cycles = 4096,
    parameter int gap_cycles    = 32
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              go,
    output logic                             strt_cnv,
    output line_follow_pkg::chan_t           chnnl,
    input  wire                              cnv_cmplt,
    input  wire [line_follow_pkg::a2d_w-1:0] a2d_res,
    output logic                             ir_in_en,
    output logic                             ir_mid_en,
    output logic                             ir_out_en,
    output logic [7:0]                       LEDs,
    output line_follow_pkg::motor_cmd_t      motor,
    output logic                             mtr_upd
);

    logic                       emit_en;
    line_follow_pkg::ir_pair_t  emit_pair;
    line_follow_pkg::sample_t   sample;
    logic                       sample_vld;
    logic signed [11:0]         error;
    logic                       error_vld;

    sensor_sequencer #(
        .settle_cycles (settle_cycles),
        .gap_cycles    (gap_cycles)
    ) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .go         (go),
        .cnv_cmplt  (cnv_cmplt),
        .a2d_res    (a2d_res),
        .strt_cnv   (strt_cnv),
        .chnnl      (chnnl),
        .emit_en    (emit_en),
        .emit_pair  (emit_pair),
        .sample     (sample),
        .sample_vld (sample_vld)
    );

    ir_emitter_pwm u_pwm (
        .clk       (clk),
        .rst_n     (rst_n),
        .emit_en   (emit_en),
        .emit_pair (emit_pair),
        .ir_in_en  (ir_in_en),
        .ir_mid_en (ir_mid_en),
        .ir_out_en (ir_out_en)
    );

    error_accum u_err (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample     (sample),
        .sample_vld (sample_vld),
        .error      (error),
        .error_vld  (error_vld),
        .LEDs       (LEDs)
    );

    pi_controller u_pi (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (go),
        .error     (error),
        .error_vld (error_vld),
        .motor     (motor),
        .mtr_upd   (mtr_upd)
    );

endmodule

`default_nettype wire

// File: rtl/pi_controller.sv
/* PI motor controller
   integral and forward ramp every fourth frame, one shared
   registered multiplier, then right/left motor sums */
`timescale 1ns/10ps
`default_nettype none

module pi_controller (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           go,
    input  wire signed [11:0]             error,
    input  wire                           error_vld,
    output line_follow_pkg::motor_cmd_t   motor,
    output logic                          mtr_upd
);

    localparam logic [2:0] step_last = 3'd5;

    logic [1:0]         int_cnt;
    logic               int_upd;
    logic signed [11:0] integral;
    logic signed [15:0] int_sum;
    logic [10:0]        fwd;
    logic [2:0]         step;      // 0 idle, 1..5 pipeline steps

    logic signed [11:0] op_a;
    logic signed [14:0] op_b;
    logic signed [26:0] prod;
    logic signed [15:0] i_comp;
    logic signed [15:0] p_comp;
    logic signed [15:0] corr;
    logic signed [15:0] rht_sum;
    logic signed [15:0] lft_sum;
    logic signed [11:0] rht_sat;
    logic signed [11:0] lft_sat;

    assign int_upd = error_vld && (int_cnt == 2'd3);
    assign int_sum = integral + error;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_cnt  <= '0;
            integral <= '0;
            fwd      <= '0;
        end else begin
            if (error_vld)
                int_cnt <= int_cnt + 1'b1;
            if (int_upd)
                integral <= line_follow_pkg::sat12(int_sum);
            if (!go)
                fwd <= '0;
            else if (int_upd && fwd != line_follow_pkg::fwd_max)
                fwd <= fwd + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            step <= '0;
        else if (error_vld)
            step <= 3'd1;
        else if (step == step_last)
            step <= '0;
        else if (step != '0)
            step <= step + 1'b1;
    end

    // steps 1-2 integral term, 3-4 proportional term
    always_comb begin
        if (step >= 3'd3) begin
            op_a = error;
            op_b = $signed({1'b0, line_follow_pkg::p_term});
        end else begin
            op_a = integral;
            op_b = $signed({3'b000, line_follow_pkg::i_term});
        end
    end

    always_ff @(posedge clk) begin
        prod <= op_a * op_b;
        if (step == 3'd2)
            i_comp <= prod[26:11];                    // >>> 11
        if (step == 3'd4)
            p_comp <= {{2{prod[26]}}, prod[26:13]};   // >>> 13
    end

    always_comb begin
        corr    = i_comp + p_comp;
        rht_sum = $signed({5'b00000, fwd}) - corr;
        lft_sum = $signed({5'b00000, fwd}) + corr;
        rht_sat = line_follow_pkg::sat12(rht_sum);
        lft_sat = line_follow_pkg::sat12(lft_sum);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            motor   <= '0;
            mtr_upd <= 1'b0;
        end else begin
            mtr_upd <= (step == step_last);
            if (step == step_last) begin
                motor.rht <= rht_sat[11:1];   // lsb dropped
                motor.lft <= lft_sat[11:1];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/sensor_sequencer.sv
/* sensor sequencer
   walks the three IR pairs, settles the emitters, runs the A2D
   strobe/complete handshake and hands each reading downstream */
`timescale 1ns/10ps
`default_nettype none

module sensor_sequencer #(
    parameter int settle_cycles = 4096,
    parameter int gap_cycles    = 32
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                go,
    input  wire                                cnv_cmplt,
    input  wire [line_follow_pkg::a2d_w-1:0]   a2d_res,
    output logic                               strt_cnv,
    output line_follow_pkg::chan_t             chnnl,
    output logic                               emit_en,
    output line_follow_pkg::ir_pair_t          emit_pair,
    output line_follow_pkg::sample_t           sample,
    output logic                               sample_vld
);

    localparam int tmr_max = (settle_cycles > gap_cycles) ? settle_cycles : gap_cycles;
    localparam int tmr_w   = $clog2(tmr_max + 1);
    localparam logic [2:0] last_idx = 3'd5;

    typedef enum logic [1:0] {
        seq_idle,
        seq_settle,
        seq_cnv,
        seq_gap
    } seq_state_t;

    seq_state_t       state;
    logic [tmr_w-1:0] timer;     // shared by settle and gap waits
    logic [2:0]       idx;       // position in scan order
    logic             seen_low;
    logic             cnv_done;

    assign chnnl     = line_follow_pkg::chan_at(idx);
    assign emit_pair = line_follow_pkg::ir_pair_t'(idx[2:1]);
    assign cnv_done  = (state == seq_cnv) && cnv_cmplt && seen_low;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= seq_idle;
            timer      <= '0;
            idx        <= '0;
            seen_low   <= 1'b0;
            strt_cnv   <= 1'b0;
            emit_en    <= 1'b0;
            sample_vld <= 1'b0;
        end else begin
            strt_cnv   <= 1'b0;
            sample_vld <= 1'b0;
            case (state)
                seq_idle: begin
                    if (go) begin
                        state   <= seq_settle;
                        emit_en <= 1'b1;
                        timer   <= tmr_w'(settle_cycles - 1);
                    end
                end
                seq_settle: begin
                    emit_en <= 1'b1;
                    if (timer == '0) begin
                        strt_cnv <= 1'b1;
                        state    <= seq_cnv;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                seq_gap: begin
                    if (timer == '0) begin
                        strt_cnv <= 1'b1;
                        state    <= seq_cnv;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                seq_cnv: begin
                    if (!cnv_cmplt) begin
                        seen_low <= 1'b1;
                    end else if (seen_low) begin
                        seen_low   <= 1'b0;
                        sample_vld <= 1'b1;
                        if (!idx[0]) begin
                            idx   <= idx + 1'b1;
                            timer <= tmr_w'(gap_cycles - 1);
                            state <= seq_gap;
                        end else if (idx == last_idx) begin
                            emit_en <= 1'b0;
                            idx     <= '0;
                            state   <= seq_idle;
                        end else begin
                            // one cycle dark so the PWM restarts on the next pair
                            emit_en <= 1'b0;
                            idx     <= idx + 1'b1;
                            timer   <= tmr_w'(settle_cycles);
                            state   <= seq_settle;
                        end
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cnv_done) begin
            sample.value  <= a2d_res;
            sample.pair   <= line_follow_pkg::ir_pair_t'(idx[2:1]);
            sample.negate <= idx[0];
            sample.last   <= (idx == last_idx);
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the motion controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module motion_cntrl_tb -f verilog.f -o motion_cntrl_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/motion_cntrl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0

// File: sim/motion_cntrl_props.sv
/* motion controller assertions
   strobe widths, lit emitter pair and channel hold */
`timescale 1ns/10ps
`default_nettype none

module motion_cntrl_props (
    input wire       clk,
    input wire       rst_n,
    input wire       strt_cnv,
    input wire [2:0] chnnl,
    input wire       ir_in_en,
    input wire       ir_mid_en,
    input wire       ir_out_en,
    input wire       mtr_upd
);

    a_strt_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        strt_cnv |=> !strt_cnv)
        else $error("strt_cnv held longer than one cycle");

    a_upd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mtr_upd |=> !mtr_upd)
        else $error("mtr_upd held longer than one cycle");

    // only the pair owning the converted channel may be lit
    a_emit_pair: assert property (@(posedge clk) disable iff (!rst_n)
        (!ir_in_en  || chnnl == 3'd1 || chnnl == 3'd0) &&
        (!ir_mid_en || chnnl == 3'd4 || chnnl == 3'd2) &&
        (!ir_out_en || chnnl == 3'd3 || chnnl == 3'd7))
        else $error("emitter on for a pair other than the one converted");

    // converter input must not move mid conversion
    a_chan_hold: assert property (@(posedge clk) disable iff (!rst_n)
        strt_cnv |=> $stable(chnnl))
        else $error("chnnl changed right after strt_cnv");

endmodule

bind motion_cntrl motion_cntrl_props props (
    .clk       (clk),
    .rst_n     (rst_n),
    .strt_cnv  (strt_cnv),
    .chnnl     (chnnl),
    .ir_in_en  (ir_in_en),
    .ir_mid_en (ir_mid_en),
    .ir_out_en (ir_out_en),
    .mtr_upd   (mtr_upd)
);

`default_nettype wire

// File: sim/motion_cntrl_tb.sv
/* motion controller testbench
   A2D model with random readings, reference model of the steering
   error and PI path, checks on channel order, emitters and motors */
`timescale 1ns/10ps
`default_nettype none

module motion_cntrl_tb;

    localparam int settle_cycles = 64;
    localparam int gap_cycles    = 8;
    localparam int num_frames    = 10;
    localparam int frame_cycles  = 3 * (settle_cycles + gap_cycles) + 2 * 3 * 12 + 20;
    localparam int duty          = 140;
    localparam int fwd_ceiling   = 1792;

    logic                        clk;
    logic                        rst_n;
    logic                        go;
    logic                        strt_cnv;
    line_follow_pkg::chan_t      chnnl;
    logic                        cnv_cmplt;
    logic [11:0]                 a2d_res;
    logic                        ir_in_en, ir_mid_en, ir_out_en;
    logic [7:0]                  LEDs;
    line_follow_pkg::motor_cmd_t motor;
    logic                        mtr_upd;
    logic [2:0]                  emit_vec;

    integer seed;
    integer cyc = 0;
    integer conv_cnt = 0;
    integer frames_done = 0;
    integer errors = 0;
    integer tests_run = 0;
    integer frame_mark = 0;
    integer chan_errs = 0;
    integer emit_errs = 0;
    integer golow_errs = 0;
    integer run_len = 0;
    integer runs_seen = 0;
    integer m_integral = 0;
    integer m_fwd = 0;
    integer m_frames = 0;
    integer rd [0:7];
    integer order [0:5] = '{1, 0, 4, 2, 3, 7};
    integer mode [0:9] = '{1, 2, 3, 1, 0, 1, 1, 1, 3, 0};   // 0 random, 1 centered, 2/3 hard
    integer exp_cyc [$];
    integer exp_leds [$];
    integer exp_rht [$];
    integer exp_lft [$];

    motion_cntrl #(
        .settle_cycles (settle_cycles),
        .gap_cycles    (gap_cycles)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (go),
        .strt_cnv  (strt_cnv),
        .chnnl     (chnnl),
        .cnv_cmplt (cnv_cmplt),
        .a2d_res   (a2d_res),
        .ir_in_en  (ir_in_en),
        .ir_mid_en (ir_mid_en),
        .ir_out_en (ir_out_en),
        .LEDs      (LEDs),
        .motor     (motor),
        .mtr_upd   (mtr_upd)
    );

    assign emit_vec = {ir_out_en, ir_mid_en, ir_in_en};

    function automatic integer clamp_s12(input integer v);
        if (v > 2047)
            return 2047;
        if (v < -2048)
            return -2048;
        return v;
    endfunction

    // 0 inner, 1 mid, 2 outer
    function automatic integer pair_of(input integer ch);
        case (ch)
            1, 0:    return 0;
            4, 2:    return 1;
            default: return 2;
        endcase
    endfunction

    task automatic fail_value(input string name, input integer got, input integer exp);
        errors = errors + 1;
        $display("[FAIL] %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
    endtask

    task automatic end_test(input string name, input integer errs);
        tests_run = tests_run + 1;
        if (errs == 0)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errs);
    endtask

    task automatic predict_frame(input integer done_cyc);
        integer e;
        integer corr;
        integer rht;
        integer lft;
        e = clamp_s12(rd[1] - rd[0] + 2 * (rd[4] - rd[2]) + 4 * (rd[3] - rd[7]));
        if (!go)
            m_fwd = 0;
        if (m_frames % 4 == 3) begin   // every fourth frame
            m_integral = clamp_s12(m_integral + e);
            if (go && m_fwd < fwd_ceiling)
                m_fwd = m_fwd + 1;
        end
        corr = ((m_integral * 1280) >>> 11) + ((e * 13952) >>> 13);
        rht  = clamp_s12(m_fwd - corr);
        lft  = clamp_s12(m_fwd + corr);
        m_frames = m_frames + 1;
        // completion seen next edge, error_vld one later, then 6 PI cycles
        exp_cyc.push_back(done_cyc + 2 + 6);
        exp_leds.push_back((e >>> 4) & 8'hff);
        exp_rht.push_back((rht >>> 1) & 11'h7ff);
        exp_lft.push_back((lft >>> 1) & 11'h7ff);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        #(2 * (num_frames * frame_cycles + frame_cycles) * 10);   // frames plus go low hold
        $display("timeout: the frames did not complete in time");
        $display("Done: errors found");
        $finish;
    end

    // A2D converter, one reading per strt_cnv
    initial begin : a2d_model
        integer ch;
        integer pos;
        integer dly;
        integer val;
        cnv_cmplt = 1'b1;
        a2d_res   = '0;
        forever begin
            @(posedge clk);
            #1;
            if (strt_cnv === 1'b1) begin
                ch  = chnnl;
                pos = conv_cnt % 6;
                if (ch != order[pos]) begin
                    chan_errs = chan_errs + 1;
                    fail_value("chnnl", ch, order[pos]);
                end
                case (mode[(conv_cnt / 6) % num_frames])
                    0:       val = $random(seed) & 12'hfff;
                    1:       val = 1984 + ($random(seed) & 127);
                    2:       val = (pos % 2 == 0) ? 4095 : 0;
                    default: val = (pos % 2 == 0) ? 0 : 4095;
                endcase
                conv_cnt  = conv_cnt + 1;
                cnv_cmplt = 1'b0;
                dly = 2 + ($random(seed) & 7);
                repeat (dly) @(posedge clk);
                #1;
                rd[ch]    = val;
                a2d_res   = val[11:0];
                cnv_cmplt = 1'b1;
                if (ch == 7)
                    predict_frame(cyc);
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (strt_cnv && !go) begin
                golow_errs = golow_errs + 1;
                errors = errors + 1;
                $display("strt_cnv pulsed at %0d ns while go was low", $time);
            end
            if (emit_vec != 3'b000 && emit_vec != (3'b001 << pair_of(chnnl))) begin
                emit_errs = emit_errs + 1;
                fail_value("emitter outputs", emit_vec, 1 << pair_of(chnnl));
            end
            if (emit_vec != 3'b000) begin
                run_len = run_len + 1;
            end else if (run_len != 0) begin
                // on through the settle, never past one duty phase
                if (run_len < settle_cycles || run_len > duty) begin
                    emit_errs = emit_errs + 1;
                    fail_value("emitter high cycles", run_len, duty);
                end
                runs_seen = runs_seen + 1;
                run_len = 0;
            end
            if (mtr_upd) begin
                if (exp_cyc.size() == 0) begin
                    errors = errors + 1;
                    $display("mtr_upd pulsed at %0d ns with no frame outstanding", $time);
                end else begin
                    if (cyc != exp_cyc[0])
                        fail_value("mtr_upd cycle", cyc, exp_cyc[0]);
                    if (LEDs != exp_leds[0])
                        fail_value("LEDs", LEDs, exp_leds[0]);
                    if (motor.rht != exp_rht[0])
                        fail_value("motor.rht", motor.rht, exp_rht[0]);
                    if (motor.lft != exp_lft[0])
                        fail_value("motor.lft", motor.lft, exp_lft[0]);
                    void'(exp_cyc.pop_front());
                    void'(exp_leds.pop_front());
                    void'(exp_rht.pop_front());
                    void'(exp_lft.pop_front());
                    end_test($sformatf("frame %0d", frames_done), errors - frame_mark);
                    frame_mark  = errors;
                    frames_done = frames_done + 1;
                end
            end
        end
    end

    initial begin
        seed  = 13;
        go    = 1'b0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        if ({strt_cnv, mtr_upd, emit_vec} != 5'b00000)
            fail_value("strobes and emitters", {strt_cnv, mtr_upd, emit_vec}, 0);
        if (LEDs != 8'h00)
            fail_value("LEDs", LEDs, 0);
        if (motor != '0)
            fail_value("motor", motor, 0);
        end_test("reset", errors);
        frame_mark = errors;
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1 go = 1'b1;
        // drop go during the last conversion of frame 5, sequencer parks in idle
        wait (conv_cnt == 36);
        @(posedge clk);
        #1 go = 1'b0;
        wait (frames_done == 6);
        repeat (frame_cycles) @(posedge clk);
        #1 go = 1'b1;
        end_test("go low", golow_errs);
        wait (frames_done == num_frames);
        @(posedge clk);
        end_test("channel order", chan_errs);
        if (runs_seen < 3 * num_frames) begin
            emit_errs = emit_errs + 1;
            errors = errors + 1;
            $display("emitters switched on only %0d times", runs_seen);
        end
        end_test("emitters", emit_errs);
        $display("tests: %0d, errors: %0d", tests_run, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/line_follow_pkg.sv
rtl/sensor_sequencer.sv
rtl/ir_emitter_pwm.sv
rtl/error_accum.sv
rtl/pi_controller.sv
rtl/motion_cntrl.sv
sim/motion_cntrl_props.sv
sim/motion_cntrl_tb.sv
